// File: source/ntm_matrix_params.svh
/*
  Width settings for the element-wise modular matrix adder.
  Included by the package, the RTL stages and the testbench.
*/

`ifndef NTM_MATRIX_PARAMS_SVH
`define NTM_MATRIX_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////////////////////////

// Data word, also used for the modulo and the matrix sizes
`define NTM_DATA_SIZE 16

// Row and column counters, limits a matrix to 256 by 256
`define NTM_INDEX_SIZE 8

`endif

// File: source/ntm_matrix_pkg.sv
/*
  Types shared by the matrix adder pipeline stages.
  Every stage takes them with a wildcard import in its module header.
*/

`include "ntm_matrix_params.svh"

package ntm_matrix_pkg;

  //////////////////////////////////////////////////////////////////////
  // Scalar types
  //////////////////////////////////////////////////////////////////////

  typedef logic [`NTM_DATA_SIZE-1:0]  data_word_t;
  typedef logic [`NTM_INDEX_SIZE-1:0] index_t;

  //////////////////////////////////////////////////////////////////////
  // Stage payloads
  //////////////////////////////////////////////////////////////////////

  // Job configuration, latched once per matrix
  typedef struct packed {
    logic       operation;  // 0 add, 1 subtract
    data_word_t modulo;
    data_word_t size_i;     // Rows
    data_word_t size_j;     // Columns
  } matrix_config_t;

  // One element's operands out of the capture stage
  typedef struct packed {
    logic       valid;
    data_word_t a_value;
    data_word_t b_value;
  } operand_pair_t;

  // Operand pair with position tags out of the tracker
  typedef struct packed {
    logic       valid;
    data_word_t a_value;
    data_word_t b_value;
    logic       row_end;
    logic       matrix_end;
  } tagged_pair_t;

endpackage

// File: source/ntm_matrix_pair_capture.sv
/*
  First pipeline stage of the matrix adder.
  Holds A and B separately until both have arrived, then issues one pair.
*/

`timescale 1ns/1ps

`include "ntm_matrix_params.svh"

module ntm_matrix_pair_capture
  import ntm_matrix_pkg::*;
(
  input  logic                      CLK,
  input  logic                      RST,
  input  logic [`NTM_DATA_SIZE-1:0] DATA_A_IN,
  input  logic [`NTM_DATA_SIZE-1:0] DATA_B_IN,
  input  logic                      DATA_A_IN_ENABLE,
  input  logic                      DATA_B_IN_ENABLE,
  output operand_pair_t             pair_stage
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // Pending operands and their held flags
  data_word_t pend_a;
  data_word_t pend_b;
  logic       held_a;
  logic       held_b;

  // Registered pair
  logic       pair_valid_q;
  data_word_t pair_a_q;
  data_word_t pair_b_q;

  logic pair_fire;
  logic capture_a;
  logic capture_b;

  //////////////////////////////////////////////////////////////////////
  // Pairing
  //////////////////////////////////////////////////////////////////////

  // Both sides present, held or strobed now
  assign pair_fire = (held_a | DATA_A_IN_ENABLE) & (held_b | DATA_B_IN_ENABLE);

  // Keep a new operand unless it is consumed this cycle
  // A held operand pairs first, so a new strobe beside it is kept for later
  assign capture_a = DATA_A_IN_ENABLE & (~pair_fire | held_a);
  assign capture_b = DATA_B_IN_ENABLE & (~pair_fire | held_b);

  // Held flags
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      held_a       <= 1'b0;
      held_b       <= 1'b0;
      pair_valid_q <= 1'b0;
    end else begin
      held_a       <= capture_a | (held_a & ~pair_fire);
      held_b       <= capture_b | (held_b & ~pair_fire);
      pair_valid_q <= pair_fire;
    end
  end

  // Operand storage
  always_ff @(posedge CLK) begin
    if (capture_a) begin
      pend_a <= DATA_A_IN;
    end
    if (capture_b) begin
      pend_b <= DATA_B_IN;
    end
    if (pair_fire) begin
      // Held value wins over the live input
      pair_a_q <= held_a ? pend_a : DATA_A_IN;
      pair_b_q <= held_b ? pend_b : DATA_B_IN;
    end
  end

  // Valid for exactly one cycle
  assign pair_stage = '{valid: pair_valid_q, a_value: pair_a_q, b_value: pair_b_q};

endmodule

// File: source/ntm_matrix_index_tracker.sv
/*
  Second pipeline stage of the matrix adder.
  Latches the job on START, counts rows and columns of incoming pairs,
  and tags the last element of each row and of the matrix.
*/

`timescale 1ns/1ps

`include "ntm_matrix_params.svh"

module ntm_matrix_index_tracker
  import ntm_matrix_pkg::*;
(
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      START,
  input  logic                      OPERATION,
  input  logic [`NTM_DATA_SIZE-1:0] MODULO_IN,
  input  logic [`NTM_DATA_SIZE-1:0] SIZE_I_IN,
  input  logic [`NTM_DATA_SIZE-1:0] SIZE_J_IN,
  input  operand_pair_t             pair_stage,
  output tagged_pair_t              tagged_stage,
  output matrix_config_t            job_config
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // Job state
  logic   active;
  index_t row_count;
  index_t col_count;

  // Registered tagged pair
  logic       tag_valid_q;
  logic       row_end_q;
  logic       matrix_end_q;
  data_word_t tag_a_q;
  data_word_t tag_b_q;

  logic       start_accept;
  logic       pair_accept;
  logic       last_col;
  logic       last_row;
  data_word_t last_col_index;
  data_word_t last_row_index;

  //////////////////////////////////////////////////////////////////////
  // Position decode
  //////////////////////////////////////////////////////////////////////

  // START only counts while idle
  assign start_accept = START & ~active;

  // Pairs outside a job are dropped here
  assign pair_accept = pair_stage.valid & active;

  assign last_col_index = job_config.size_j - 1'b1;
  assign last_row_index = job_config.size_i - 1'b1;

  // Counters zero-extended to the data width
  assign last_col = (data_word_t'(col_count) == last_col_index);
  assign last_row = (data_word_t'(row_count) == last_row_index);

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      active       <= 1'b0;
      row_count    <= '0;
      col_count    <= '0;
      tag_valid_q  <= 1'b0;
      row_end_q    <= 1'b0;
      matrix_end_q <= 1'b0;
    end else begin
      tag_valid_q  <= pair_accept;
      row_end_q    <= pair_accept & last_col;
      matrix_end_q <= pair_accept & last_col & last_row;
      if (start_accept) begin
        active    <= 1'b1;
        row_count <= '0;
        col_count <= '0;
      end else if (pair_accept) begin
        if (last_col) begin
          // Wrap to the next row
          col_count <= '0;
          row_count <= row_count + 1'b1;
          // Last element seen, back to idle
          if (last_row) begin
            active <= 1'b0;
          end
        end else begin
          col_count <= col_count + 1'b1;
        end
      end
    end
  end

  // Configuration and operands
  always_ff @(posedge CLK) begin
    if (start_accept) begin
      job_config <= '{operation: OPERATION, modulo: MODULO_IN,
                      size_i: SIZE_I_IN, size_j: SIZE_J_IN};
    end
    if (pair_accept) begin
      tag_a_q <= pair_stage.a_value;
      tag_b_q <= pair_stage.b_value;
    end
  end

  assign tagged_stage = '{valid: tag_valid_q, a_value: tag_a_q, b_value: tag_b_q,
                          row_end: row_end_q, matrix_end: matrix_end_q};

endmodule

// File: source/ntm_matrix_modular_addsub.sv
/*
  Third pipeline stage of the matrix adder.
  Computes (a + b) mod m or (a - b) mod m for each tagged pair and
  drives the registered data output and strobes.
*/

`timescale 1ns/1ps

`include "ntm_matrix_params.svh"

module ntm_matrix_modular_addsub
  import ntm_matrix_pkg::*;
(
  input  logic                      CLK,
  input  logic                      RST,
  input  tagged_pair_t              tagged_stage,
  input  matrix_config_t            job_config,
  output logic [`NTM_DATA_SIZE-1:0] DATA_OUT,
  output logic                      DATA_OUT_I_ENABLE,
  output logic                      DATA_OUT_J_ENABLE,
  output logic                      READY
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // Sum with one carry bit
  logic [`NTM_DATA_SIZE:0] sum_wide;
  logic [`NTM_DATA_SIZE:0] modulo_wide;
  logic [`NTM_DATA_SIZE:0] sum_reduced;

  data_word_t add_result;
  data_word_t sub_result;
  data_word_t result;

  //////////////////////////////////////////////////////////////////////
  // Modular arithmetic
  //////////////////////////////////////////////////////////////////////

  // Add, one conditional subtraction suffices for operands below m
  assign sum_wide    = {1'b0, tagged_stage.a_value} + {1'b0, tagged_stage.b_value};
  assign modulo_wide = {1'b0, job_config.modulo};
  assign sum_reduced = (sum_wide >= modulo_wide) ? (sum_wide - modulo_wide) : sum_wide;
  assign add_result  = sum_reduced[`NTM_DATA_SIZE-1:0];

  // Subtract, wrap by m on borrow
  always_comb begin
    if (tagged_stage.a_value >= tagged_stage.b_value) begin
      sub_result = tagged_stage.a_value - tagged_stage.b_value;
    end else begin
      sub_result = tagged_stage.a_value - tagged_stage.b_value + job_config.modulo;
    end
  end

  assign result = job_config.operation ? sub_result : add_result;

  //////////////////////////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      DATA_OUT          <= '0;
      DATA_OUT_J_ENABLE <= 1'b0;
      DATA_OUT_I_ENABLE <= 1'b0;
      READY             <= 1'b0;
    end else begin
      // One pulse per element, row and matrix ends ride along
      DATA_OUT_J_ENABLE <= tagged_stage.valid;
      DATA_OUT_I_ENABLE <= tagged_stage.valid & tagged_stage.row_end;
      READY             <= tagged_stage.valid & tagged_stage.matrix_end;
      // Last result holds between elements
      if (tagged_stage.valid) begin
        DATA_OUT <= result;
      end
    end
  end

endmodule

// File: source/ntm_matrix_adder.sv
/*
  Element-wise modular matrix adder, top level.
  Chains operand pairing, index tracking and modular add/subtract,
  three cycles from the later operand strobe to the output strobe.
*/

`timescale 1ns/1ps

`include "ntm_matrix_params.svh"

module ntm_matrix_adder
  import ntm_matrix_pkg::*;
(
  // Global
  input  logic                      CLK,
  input  logic                      RST,

  // Control
  input  logic                      START,
  output logic                      READY,
  input  logic                      OPERATION,

  // Job configuration, sampled with START
  input  logic [`NTM_DATA_SIZE-1:0] MODULO_IN,
  input  logic [`NTM_DATA_SIZE-1:0] SIZE_I_IN,
  input  logic [`NTM_DATA_SIZE-1:0] SIZE_J_IN,

  // Operand streams
  input  logic [`NTM_DATA_SIZE-1:0] DATA_A_IN,
  input  logic                      DATA_A_IN_ENABLE,
  input  logic [`NTM_DATA_SIZE-1:0] DATA_B_IN,
  input  logic                      DATA_B_IN_ENABLE,

  // Result stream
  output logic [`NTM_DATA_SIZE-1:0] DATA_OUT,
  output logic                      DATA_OUT_I_ENABLE,
  output logic                      DATA_OUT_J_ENABLE
);

  //////////////////////////////////////////////////////////////////////
  // Stage links
  //////////////////////////////////////////////////////////////////////

  operand_pair_t  pair_stage;
  tagged_pair_t   tagged_stage;
  matrix_config_t job_config;

  //////////////////////////////////////////////////////////////////////
  // Pipeline
  //////////////////////////////////////////////////////////////////////

  // Stage 1, pairs A with B in arrival order
  ntm_matrix_pair_capture pair_capture (
    .CLK              (CLK),
    .RST              (RST),
    .DATA_A_IN        (DATA_A_IN),
    .DATA_B_IN        (DATA_B_IN),
    .DATA_A_IN_ENABLE (DATA_A_IN_ENABLE),
    .DATA_B_IN_ENABLE (DATA_B_IN_ENABLE),
    .pair_stage       (pair_stage)
  );

  // Stage 2, job control and row/column tags
  ntm_matrix_index_tracker index_tracker (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .OPERATION    (OPERATION),
    .MODULO_IN    (MODULO_IN),
    .SIZE_I_IN    (SIZE_I_IN),
    .SIZE_J_IN    (SIZE_J_IN),
    .pair_stage   (pair_stage),
    .tagged_stage (tagged_stage),
    .job_config   (job_config)
  );

  // Stage 3, modular result and output strobes
  ntm_matrix_modular_addsub modular_addsub (
    .CLK               (CLK),
    .RST               (RST),
    .tagged_stage      (tagged_stage),
    .job_config        (job_config),
    .DATA_OUT          (DATA_OUT),
    .DATA_OUT_I_ENABLE (DATA_OUT_I_ENABLE),
    .DATA_OUT_J_ENABLE (DATA_OUT_J_ENABLE),
    .READY             (READY)
  );

endmodule

// File: dv/ntm_matrix_checker.sv
/*
  Scoreboard for the matrix adder testbench.
  Watches the DUT ports, models job control and operand pairing, and
  compares every output strobe with a reference result and tags.
*/

`timescale 1ns/1ps

`include "ntm_matrix_params.svh"

module ntm_matrix_checker (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      START,
  input  logic                      OPERATION,
  input  logic [`NTM_DATA_SIZE-1:0] MODULO_IN,
  input  logic [`NTM_DATA_SIZE-1:0] SIZE_I_IN,
  input  logic [`NTM_DATA_SIZE-1:0] SIZE_J_IN,
  input  logic [`NTM_DATA_SIZE-1:0] DATA_A_IN,
  input  logic                      DATA_A_IN_ENABLE,
  input  logic [`NTM_DATA_SIZE-1:0] DATA_B_IN,
  input  logic                      DATA_B_IN_ENABLE,
  input  logic [`NTM_DATA_SIZE-1:0] DATA_OUT,
  input  logic                      DATA_OUT_I_ENABLE,
  input  logic                      DATA_OUT_J_ENABLE,
  input  logic                      READY,
  output int                        error_count,
  output int                        check_count,
  output int                        test_count,
  output int                        pending_count
);

  // One expected output with the sampling edge of its later strobe
  typedef struct packed {
    logic [`NTM_DATA_SIZE-1:0] value;
    logic                      row_end;
    logic                      matrix_end;
    logic [31:0]               cycle;
  } expected_t;

  expected_t                 expected_q[$];
  logic [`NTM_DATA_SIZE-1:0] a_q[$];
  logic [`NTM_DATA_SIZE-1:0] b_q[$];

  // Job model
  logic job_active;
  logic job_op;
  int   job_mod;
  int   job_i;
  int   job_j;
  int   elem_index;
  int   cycle_count;
  int   errors_mark;
  int   test_checks;

  //////////////////////////////////////////////////////////////////////
  // Reference and reporting
  //////////////////////////////////////////////////////////////////////

  // Operands are below m, so a - b + m stays positive
  function automatic logic [`NTM_DATA_SIZE-1:0] reference_result(input logic op,
                                                                 input int a, input int b,
                                                                 input int m);
    int r;
    if (op) begin
      r = (a - b + m) % m;
    end else begin
      r = (a + b) % m;
    end
    return r[`NTM_DATA_SIZE-1:0];
  endfunction

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual) begin
      error_count = error_count + 1;
      $display("** Error: %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual,
               $time);
    end
  endtask

  task automatic report_problem(input string what);
    error_count = error_count + 1;
    $display("Error: %s at %0t", what, $time);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Monitor
  //////////////////////////////////////////////////////////////////////

  always @(posedge CLK or posedge RST) begin : watch
    expected_t                 item;
    logic [`NTM_DATA_SIZE-1:0] a_val;
    logic [`NTM_DATA_SIZE-1:0] b_val;
    if (RST) begin
      expected_q.delete();
      a_q.delete();
      b_q.delete();
      job_active    = 1'b0;
      elem_index    = 0;
      cycle_count   = 0;
      error_count   = 0;
      check_count   = 0;
      test_count    = 0;
      pending_count = 0;
      errors_mark   = 0;
      test_checks   = 0;
    end else begin
      cycle_count = cycle_count + 1;
      // Output side first, values are those before this edge
      if (DATA_OUT_J_ENABLE) begin
        if (expected_q.size() == 0) begin
          report_problem("output strobe with no element in flight");
        end else begin
          item        = expected_q.pop_front();
          check_count = check_count + 1;
          test_checks = test_checks + 1;
          compare_value("DATA_OUT", item.value, DATA_OUT);
          compare_value("DATA_OUT_I_ENABLE", item.row_end, DATA_OUT_I_ENABLE);
          compare_value("READY", item.matrix_end, READY);
          if (cycle_count - item.cycle != 3) begin
            report_problem($sformatf("element came out %0d cycles after its strobes, not 3",
                                     cycle_count - item.cycle));
          end
          // Matrix done closes one test
          if (READY) begin
            test_count = test_count + 1;
            $display("Test %0d finished: %0d elements checked, %0d errors", test_count,
                     test_checks, error_count - errors_mark);
            errors_mark = error_count;
            test_checks = 0;
          end
        end
      end else if (DATA_OUT_I_ENABLE || READY) begin
        report_problem("row end or ready pulsed without an output strobe");
      end
      // START only counts while idle
      if (START && !job_active) begin
        job_active = 1'b1;
        job_op     = OPERATION;
        job_mod    = MODULO_IN;
        job_i      = SIZE_I_IN;
        job_j      = SIZE_J_IN;
        elem_index = 0;
      end
      if (DATA_A_IN_ENABLE) begin
        a_q.push_back(DATA_A_IN);
      end
      if (DATA_B_IN_ENABLE) begin
        b_q.push_back(DATA_B_IN);
      end
      // Pairs in arrival order, dropped outside a job
      if (a_q.size() > 0 && b_q.size() > 0) begin
        a_val = a_q.pop_front();
        b_val = b_q.pop_front();
        if (job_active) begin
          item.value      = reference_result(job_op, a_val, b_val, job_mod);
          item.row_end    = (elem_index % job_j) == job_j - 1;
          item.matrix_end = elem_index == job_i * job_j - 1;
          item.cycle      = cycle_count;
          expected_q.push_back(item);
          elem_index = elem_index + 1;
          if (item.matrix_end) begin
            job_active = 1'b0;
          end
        end
      end
      pending_count = expected_q.size();
    end
  end

endmodule

// File: dv/ntm_matrix_adder_tb.sv
/*
  Testbench top for the matrix adder.
  Runs four matrices with idle strobes around them; all comparing
  happens in the checker module.
*/

`timescale 1ns/1ps

`include "ntm_matrix_params.svh"

module ntm_matrix_adder_tb;

  // 43 element pairs in all, idle ones included
  localparam int TOTAL_ELEMENTS = 43;
  localparam int TIMEOUT_CYCLES = TOTAL_ELEMENTS * 20 + 200;

  logic                      CLK;
  logic                      RST;
  logic                      START;
  logic                      OPERATION;
  logic [`NTM_DATA_SIZE-1:0] MODULO_IN;
  logic [`NTM_DATA_SIZE-1:0] SIZE_I_IN;
  logic [`NTM_DATA_SIZE-1:0] SIZE_J_IN;
  logic [`NTM_DATA_SIZE-1:0] DATA_A_IN;
  logic                      DATA_A_IN_ENABLE;
  logic [`NTM_DATA_SIZE-1:0] DATA_B_IN;
  logic                      DATA_B_IN_ENABLE;
  logic [`NTM_DATA_SIZE-1:0] DATA_OUT;
  logic                      DATA_OUT_I_ENABLE;
  logic                      DATA_OUT_J_ENABLE;
  logic                      READY;

  int error_count;
  int check_count;
  int test_count;
  int pending_count;

  ntm_matrix_adder UUT (.*);

  ntm_matrix_checker result_check (.*);

  //////////////////////////////////////////////////////////////////////
  // Clock and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge CLK);
    $display("Run stopped, no end reached after %0d cycles", TIMEOUT_CYCLES);
    $display("Test failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////////////////////////

  // One cycle of operand strobes
  task automatic strobe(input logic sa, input logic sb, input int a, input int b);
    @(posedge CLK);
    DATA_A_IN_ENABLE <= sa;
    DATA_B_IN_ENABLE <= sb;
    DATA_A_IN        <= a;
    DATA_B_IN        <= b;
  endtask

  task automatic pulse_start(input logic op, input int m, input int si, input int sj);
    @(posedge CLK);
    START            <= 1'b1;
    OPERATION        <= op;
    MODULO_IN        <= m;
    SIZE_I_IN        <= si;
    SIZE_J_IN        <= sj;
    DATA_A_IN_ENABLE <= 1'b0;
    DATA_B_IN_ENABLE <= 1'b0;
    @(posedge CLK);
    START <= 1'b0;
  endtask

  task automatic wait_ready();
    do begin
      @(posedge CLK);
    end while (READY !== 1'b1);
  endtask

  // Skew sends A and B apart in random order, mid_start adds a stray START
  task automatic run_matrix(input logic op, input int m, input int si, input int sj,
                            input bit skew, input bit mid_start);
    int a;
    int b;
    int t;
    pulse_start(op, m, si, sj);
    for (int k = 0; k < si * sj; k++) begin
      a = $urandom % m;
      b = $urandom % m;
      // Force a below b on every other element of a subtract
      if (op && (k % 2 == 0) && a > b) begin
        t = a;
        a = b;
        b = t;
      end
      if (mid_start && k == (si * sj) / 2) begin
        pulse_start(1'b0, 7, 1, 1);
      end
      if (!skew) begin
        strobe(1'b1, 1'b1, a, b);
      end else begin
        if ($urandom % 2) begin
          strobe(1'b1, 1'b0, a, 0);
          repeat ($urandom % 3) strobe(1'b0, 1'b0, 0, 0);
          strobe(1'b0, 1'b1, 0, b);
        end else begin
          strobe(1'b0, 1'b1, 0, b);
          repeat ($urandom % 3) strobe(1'b0, 1'b0, 0, 0);
          strobe(1'b1, 1'b0, a, 0);
        end
        repeat ($urandom % 3) strobe(1'b0, 1'b0, 0, 0);
      end
    end
    strobe(1'b0, 1'b0, 0, 0);
    wait_ready();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(91));
    RST              = 1'b1;
    START            = 1'b0;
    OPERATION        = 1'b0;
    MODULO_IN        = '0;
    SIZE_I_IN        = '0;
    SIZE_J_IN        = '0;
    DATA_A_IN        = '0;
    DATA_A_IN_ENABLE = 1'b0;
    DATA_B_IN        = '0;
    DATA_B_IN_ENABLE = 1'b0;
    repeat (2) @(posedge CLK);
    RST <= 1'b0;
    // Pairs while idle, must vanish
    strobe(1'b1, 1'b1, 5, 6);
    strobe(1'b1, 1'b1, 7, 8);
    strobe(1'b0, 1'b0, 0, 0);
    run_matrix(1'b0, 977, 3, 4, 1'b0, 1'b0);
    run_matrix(1'b1, 61, 2, 5, 1'b0, 1'b0);
    run_matrix(1'b0, 65521, 3, 3, 1'b1, 1'b0);
    // Starts right after the previous READY
    run_matrix(1'b1, 200, 4, 2, 1'b0, 1'b1);
    strobe(1'b1, 1'b1, 9, 3);
    strobe(1'b1, 1'b1, 1, 2);
    strobe(1'b0, 1'b0, 0, 0);
    repeat (10) @(posedge CLK);
    $display("Summary: %0d tests, %0d checks, %0d errors, %0d outputs missing",
             test_count, check_count, error_count, pending_count);
    if (error_count == 0 && pending_count == 0 && test_count == 4) begin
      $display("Test completed successfully");
    end else begin
      if (test_count != 4) begin
        $display("Only %0d of 4 matrices completed", test_count);
      end
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: ntm_matrix_adder.f
+incdir+source
source/ntm_matrix_pkg.sv
source/ntm_matrix_pair_capture.sv
source/ntm_matrix_index_tracker.sv
source/ntm_matrix_modular_addsub.sv
source/ntm_matrix_adder.sv
dv/ntm_matrix_checker.sv
dv/ntm_matrix_adder_tb.sv
